// File: design/tile_params.svh
`ifndef TILE_PARAMS_SVH
`define TILE_PARAMS_SVH

// ==============================
// Tile geometry
// ==============================
`define TILE_LANES          4
`define TILE_V_BITS         16
`define TILE_W_BITS         8
`define TILE_THRESH_BITS    16
`define TILE_SCALE_BITS     8
// Scale of 128 is unity gain
`define TILE_SCALE_SHIFT    7
`define TILE_BANK_DEPTH     8
`define TILE_ADDR_BITS      3

// APB slave widths
`define TILE_APB_ADDR_BITS  8
`define TILE_APB_DATA_BITS  32

// Membrane loses one eighth per tick
`define TILE_DECAY_SHIFT    3

`endif

// File: design/neuron_pkg.sv
`include "tile_params.svh"

package neuron_pkg;

    // One lane current, unsigned
    typedef logic [`TILE_V_BITS-1:0] current_t;

    // Membrane potential
    typedef logic [`TILE_V_BITS-1:0] membrane_t;

    // Full bank word, one current per lane
    typedef current_t [`TILE_LANES-1:0] current_word_t;

    // Signed layer key element
    typedef logic signed [`TILE_W_BITS-1:0] key_lane_t;

    typedef logic [`TILE_LANES-1:0] spike_vec_t;

endpackage

// File: design/ctrl_pkg.sv
`include "tile_params.svh"

package ctrl_pkg;

    // Word index into a current bank
    typedef logic [`TILE_ADDR_BITS-1:0] bank_addr_t;

    // Tick sequencer states
    typedef enum logic [2:0] {
        IDLE,
        SCAN,
        DRAIN,
        UPDATE,
        EMIT,
        DONE
    } seq_state_t;

endpackage

// File: design/tile_if.sv
`timescale 1ns/1ps
`include "tile_params.svh"

// Single lane write into a current bank
interface bank_wr_if import neuron_pkg::*, ctrl_pkg::*; ();
    bank_addr_t                      addr;
    logic [$clog2(`TILE_LANES)-1:0] lane;
    current_t                        data;
    logic                            en;

    modport master (output addr, lane, data, en);
    modport slave  (input  addr, lane, data, en);
endinterface

// Scan read port, data returns one cycle after rd_en
interface bank_rd_if import neuron_pkg::*, ctrl_pkg::*; ();
    bank_addr_t    addr;
    logic          rd_en;
    current_word_t data;
    logic          data_valid;
    logic          clear_busy;

    modport master  (output addr, rd_en, input data, data_valid, clear_busy);
    modport slave   (input addr, rd_en, output data, data_valid, clear_busy);
    modport monitor (input data, data_valid, clear_busy);
endinterface

// Sequencer strobes toward the neuron datapath
interface scan_if import neuron_pkg::*; ();
    logic       acc_clear;
    logic       acc_en;
    logic       update;
    logic       emit;
    spike_vec_t spikes;

    modport master  (output acc_clear, acc_en, update, emit);
    modport slave   (input acc_clear, acc_en, update, output spikes);
    modport monitor (input emit, spikes);
endinterface

// File: design/apb_load_decode.sv
`timescale 1ns/1ps
`include "tile_params.svh"

module apb_load_decode import neuron_pkg::*, ctrl_pkg::*; (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           psel,
    input  logic                           penable,
    input  logic                           pwrite,
    input  logic [`TILE_APB_ADDR_BITS-1:0] paddr,
    input  logic [`TILE_APB_DATA_BITS-1:0] pwdata,
    output logic                           pready,
    output logic [`TILE_APB_DATA_BITS-1:0] prdata,
    output logic                           pslverr,
    bank_wr_if.master                      wr,
    bank_rd_if.monitor                     rd
);

    localparam int LANE_BITS = $clog2(`TILE_LANES);

    // Stall the access phase while the consumed bank is zeroed
    assign pready = ~rd.clear_busy;

    // Write-only register space
    assign prdata  = '0;
    assign pslverr = 1'b0;

    // ==============================
    // Address and data decode
    // ==============================
    // Low bits pick the lane and the next bits the bank word
    assign wr.lane = paddr[LANE_BITS-1:0];
    assign wr.addr = bank_addr_t'(paddr[LANE_BITS +: `TILE_ADDR_BITS]);
    assign wr.data = current_t'(pwdata[`TILE_V_BITS-1:0]);

    // Completed write access lands on the closing edge
    assign wr.en = psel & penable & pwrite & pready;

    // Setup or wait state held psel in the cycle before
    a_wr_after_access: assert property (
        @(posedge clk) disable iff (!rst_n)
        wr.en |-> $past(psel)
    );

endmodule

// File: design/current_banks.sv
`timescale 1ns/1ps
`include "tile_params.svh"

module current_banks import neuron_pkg::*, ctrl_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      tick_done,
    bank_wr_if.slave  wr,
    bank_rd_if.slave  rd
);

    localparam bank_addr_t LAST_ADDR = bank_addr_t'(`TILE_BANK_DEPTH - 1);

    current_word_t bank_a [`TILE_BANK_DEPTH];
    current_word_t bank_b [`TILE_BANK_DEPTH];

    // 0 selects bank A for the coming tick
    logic       parity;
    logic       clear_active;
    bank_addr_t clear_addr;

    // Busy from the tick_done cycle to the end of the sweep
    assign rd.clear_busy = clear_active | tick_done;

    // ==============================
    // Parity and clear sweep
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            parity       <= 1'b0;
            clear_active <= 1'b0;
            clear_addr   <= '0;
        end else if (tick_done) begin
            parity       <= ~parity;
            clear_active <= 1'b1;
            clear_addr   <= '0;
        end else if (clear_active) begin
            clear_addr <= clear_addr + 1'b1;
            // Eight words, one per cycle
            if (clear_addr == LAST_ADDR)
                clear_active <= 1'b0;
        end
    end

    // ==============================
    // Storage
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int w = 0; w < `TILE_BANK_DEPTH; w++) begin
                bank_a[w] <= '0;
                bank_b[w] <= '0;
            end
        end else begin
            // Sweep works on the bank scanned by the last tick
            if (clear_active) begin
                if (parity)
                    bank_a[clear_addr] <= '0;
                else
                    bank_b[clear_addr] <= '0;
            end
            // Lane write merges into the word the next tick scans
            if (wr.en) begin
                if (parity)
                    bank_b[wr.addr][wr.lane] <= wr.data;
                else
                    bank_a[wr.addr][wr.lane] <= wr.data;
            end
        end
    end

    // Registered read, one cycle latency
    always_ff @(posedge clk) begin
        if (rd.rd_en)
            rd.data <= parity ? bank_b[rd.addr] : bank_a[rd.addr];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            rd.data_valid <= 1'b0;
        else
            rd.data_valid <= rd.rd_en;
    end

    a_no_wr_in_clear: assert property (
        @(posedge clk) disable iff (!rst_n)
        wr.en |-> !rd.clear_busy
    );

endmodule

// File: design/tick_sequencer.sv
`timescale 1ns/1ps
`include "tile_params.svh"

module tick_sequencer import ctrl_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       tick_start,
    input  bank_addr_t activity_hint,
    output logic       tick_done,
    output logic       early_exit_flag,
    output bank_addr_t max_active_idx,
    bank_rd_if.master  rd,
    scan_if.master     scan
);

    localparam bank_addr_t LAST_ADDR = bank_addr_t'(`TILE_BANK_DEPTH - 1);

    seq_state_t state;
    seq_state_t state_next;
    bank_addr_t scan_addr;
    // Address of the word now on the read port
    bank_addr_t rd_addr_q;
    logic       seen_any;
    logic       word_hit;
    logic       seen_now;
    logic       exit_now;
    logic       start;

    // ==============================
    // Scan decode
    // ==============================
    assign start    = (state == IDLE) && tick_start && !rd.clear_busy;
    assign word_hit = rd.data_valid && (|rd.data);
    // Includes the word returning this cycle
    assign seen_now = seen_any | word_hit;
    // Nothing active below the hint, skip the rest
    assign exit_now = (state == SCAN) && (scan_addr == activity_hint) && !seen_now;

    assign rd.addr  = scan_addr;
    assign rd.rd_en = (state == SCAN) && !exit_now;

    assign scan.acc_clear = start;
    assign scan.acc_en    = (state == SCAN) || (state == DRAIN);
    assign scan.update    = (state == UPDATE);
    assign scan.emit      = (state == EMIT);

    always_comb begin
        state_next = state;
        case (state)
            IDLE:   if (start) state_next = SCAN;
            SCAN:   if (exit_now || scan_addr == LAST_ADDR) state_next = DRAIN;
            // Last read still in flight
            DRAIN:  state_next = UPDATE;
            UPDATE: state_next = EMIT;
            EMIT:   state_next = DONE;
            DONE:   state_next = IDLE;
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state           <= IDLE;
            scan_addr       <= '0;
            seen_any        <= 1'b0;
            max_active_idx  <= '0;
            early_exit_flag <= 1'b0;
            tick_done       <= 1'b0;
        end else begin
            state     <= state_next;
            // One cycle after DONE
            tick_done <= (state == DONE);
            if (start) begin
                scan_addr       <= '0;
                seen_any        <= 1'b0;
                max_active_idx  <= '0;
                early_exit_flag <= 1'b0;
            end else begin
                if (rd.rd_en)
                    scan_addr <= scan_addr + 1'b1;
                // Ascending scan, latest hit is the highest
                if (word_hit) begin
                    seen_any       <= 1'b1;
                    max_active_idx <= rd_addr_q;
                end
                if (exit_now)
                    early_exit_flag <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd.rd_en)
            rd_addr_q <= scan_addr;
    end

    a_done_pulse: assert property (
        @(posedge clk) disable iff (!rst_n)
        tick_done |=> !tick_done
    );

    // Scan never wraps past the last word
    a_no_wrap: assert property (
        @(posedge clk) disable iff (!rst_n)
        (rd.rd_en && scan_addr == LAST_ADDR) |=> !rd.rd_en
    );

endmodule

// File: design/lif_execute.sv
`timescale 1ns/1ps
`include "tile_params.svh"

module lif_execute import neuron_pkg::*; (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic [`TILE_THRESH_BITS-1:0] thresh_base,
    input  logic [`TILE_SCALE_BITS-1:0]  thresh_scale,
    bank_rd_if.monitor                   rd,
    scan_if.slave                        scan
);

    localparam int V        = `TILE_V_BITS;
    localparam int PROD_W   = `TILE_THRESH_BITS + `TILE_SCALE_BITS;
    localparam int THRESH_W = PROD_W - `TILE_SCALE_SHIFT;

    logic [PROD_W-1:0]   thresh_prod;
    logic [THRESH_W-1:0] thresh_eff;
    spike_vec_t          spike_now;

    // ==============================
    // Scaled threshold
    // ==============================
    assign thresh_prod = thresh_base * thresh_scale;
    assign thresh_eff  = thresh_prod[PROD_W-1:`TILE_SCALE_SHIFT];

    for (genvar i = 0; i < `TILE_LANES; i++) begin : g_lane
        current_t    acc_q;
        membrane_t   mem_q;
        membrane_t   mem_leak;
        logic [V:0]  acc_sum;
        logic [V:0]  mem_new;

        // Saturating current sum
        assign acc_sum = {1'b0, acc_q} + {1'b0, rd.data[i]};

        // Leak then integrate
        assign mem_leak = mem_q - (mem_q >> `TILE_DECAY_SHIFT);
        assign mem_new  = {1'b0, mem_leak} + {1'b0, acc_q};

        assign spike_now[i] = ({1'b0, mem_new} >= {1'b0, thresh_eff});

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                acc_q <= '0;
                mem_q <= '0;
            end else begin
                if (scan.acc_clear)
                    acc_q <= '0;
                else if (scan.acc_en && rd.data_valid)
                    acc_q <= acc_sum[V] ? '1 : acc_sum[V-1:0];
                // Spike clears, sub-threshold overflow pins at max
                if (scan.update)
                    mem_q <= spike_now[i] ? '0 : (mem_new[V] ? '1 : mem_new[V-1:0]);
            end
        end
    end

    // Spike vector held until the next update
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            scan.spikes <= '0;
        else if (scan.update)
            scan.spikes <= spike_now;
    end

endmodule

// File: design/axis_result.sv
`timescale 1ns/1ps
`include "tile_params.svh"

module axis_result import neuron_pkg::*; (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic [`TILE_LANES*`TILE_W_BITS-1:0] layer_key,
    output spike_vec_t                          spike_out,
    output logic                                spike_valid,
    output logic [`TILE_LANES*`TILE_W_BITS-1:0] axis_state_out,
    output logic                                axis_write_en,
    scan_if.monitor                             scan
);

    localparam int W = `TILE_W_BITS;
    // Largest positive key value, stands for a spike
    localparam key_lane_t SPIKE_LEVEL = key_lane_t'((1 << (W - 1)) - 1);

    logic [`TILE_LANES*W-1:0] bound;

    // ==============================
    // Key binding per lane
    // ==============================
    for (genvar i = 0; i < `TILE_LANES; i++) begin : g_bind
        key_lane_t          key;
        logic signed [2*W-1:0] prod;

        assign key  = key_lane_t'(layer_key[i*W +: W]);
        assign prod = key * SPIKE_LEVEL;
        // Low byte only, silent lanes write zero
        assign bound[i*W +: W] = scan.spikes[i] ? prod[W-1:0] : '0;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            spike_out      <= '0;
            axis_state_out <= '0;
            spike_valid    <= 1'b0;
        end else begin
            spike_valid <= scan.emit;
            if (scan.emit) begin
                spike_out      <= scan.spikes;
                axis_state_out <= bound;
            end
        end
    end

    // State bus strobe moves with the spike strobe
    assign axis_write_en = spike_valid;

endmodule

// File: design/kitten_tile_top.sv
`timescale 1ns/1ps
`include "tile_params.svh"

module kitten_tile_top import neuron_pkg::*, ctrl_pkg::*; (
    input  logic                                clk,
    input  logic                                rst_n,
    // APB load port
    input  logic                                psel,
    input  logic                                penable,
    input  logic                                pwrite,
    input  logic [`TILE_APB_ADDR_BITS-1:0]      paddr,
    input  logic [`TILE_APB_DATA_BITS-1:0]      pwdata,
    output logic                                pready,
    output logic [`TILE_APB_DATA_BITS-1:0]      prdata,
    output logic                                pslverr,
    // Tick control
    input  logic                                tick_start,
    output logic                                tick_done,
    input  bank_addr_t                          activity_hint,
    input  logic [`TILE_THRESH_BITS-1:0]        thresh_base,
    input  logic [`TILE_SCALE_BITS-1:0]         thresh_scale,
    input  logic [`TILE_LANES*`TILE_W_BITS-1:0] layer_key,
    // Results
    output spike_vec_t                          spike_out,
    output logic                                spike_valid,
    output logic [`TILE_LANES*`TILE_W_BITS-1:0] axis_state_out,
    output logic                                axis_write_en,
    output bank_addr_t                          max_active_idx,
    output logic                                early_exit_flag
);

    bank_wr_if u_wr_if ();
    bank_rd_if u_rd_if ();
    scan_if    u_scan_if ();

    // ==============================
    // Decode
    // ==============================
    apb_load_decode u_decode (
        .clk, .rst_n, .psel, .penable, .pwrite, .paddr, .pwdata,
        .pready, .prdata, .pslverr,
        .wr (u_wr_if.master),
        .rd (u_rd_if.monitor)
    );

    tick_sequencer u_seq (
        .clk, .rst_n, .tick_start, .activity_hint,
        .tick_done, .early_exit_flag, .max_active_idx,
        .rd   (u_rd_if.master),
        .scan (u_scan_if.master)
    );

    // ==============================
    // Execute
    // ==============================
    current_banks u_banks (
        .clk, .rst_n, .tick_done,
        .wr (u_wr_if.slave),
        .rd (u_rd_if.slave)
    );

    lif_execute u_lif (
        .clk, .rst_n, .thresh_base, .thresh_scale,
        .rd   (u_rd_if.monitor),
        .scan (u_scan_if.slave)
    );

    // Result
    axis_result u_result (
        .clk, .rst_n, .layer_key,
        .spike_out, .spike_valid, .axis_state_out, .axis_write_en,
        .scan (u_scan_if.monitor)
    );

endmodule

// File: test/tb_top.sv
`timescale 1ns/1ps
`include "tile_params.svh"

module tb_top import neuron_pkg::*, ctrl_pkg::*; ();

    localparam int RESET_CYCLES = 16;
    localparam int N_TICKS      = 12;
    localparam int N_WRITES     = 72;
    // Cycle budget per tick and per APB write
    localparam int WATCHDOG_CYCLES = N_TICKS * 40 + N_WRITES * 4 + RESET_CYCLES;
    localparam int LANES = `TILE_LANES;
    localparam int DEPTH = `TILE_BANK_DEPTH;
    localparam int W     = `TILE_W_BITS;

    logic                                clk;
    logic                                rst_n;
    logic                                psel;
    logic                                penable;
    logic                                pwrite;
    logic [`TILE_APB_ADDR_BITS-1:0]      paddr;
    logic [`TILE_APB_DATA_BITS-1:0]      pwdata;
    logic                                pready;
    logic [`TILE_APB_DATA_BITS-1:0]      prdata;
    logic                                pslverr;
    logic                                tick_start;
    logic                                tick_done;
    bank_addr_t                          activity_hint;
    logic [`TILE_THRESH_BITS-1:0]        thresh_base;
    logic [`TILE_SCALE_BITS-1:0]         thresh_scale;
    logic [LANES*W-1:0]                  layer_key;
    spike_vec_t                          spike_out;
    logic                                spike_valid;
    logic [LANES*W-1:0]                  axis_state_out;
    logic                                axis_write_en;
    bank_addr_t                          max_active_idx;
    logic                                early_exit_flag;

    // Reference model state
    current_t  bank_mdl [2][DEPTH][LANES];
    logic      parity_mdl;
    membrane_t mem_mdl [LANES];
    integer    seed;
    logic      last_stalled;
    int        scales [3];

    kitten_tile_top u_dut (
        .clk, .rst_n, .psel, .penable, .pwrite, .paddr, .pwdata,
        .pready, .prdata, .pslverr,
        .tick_start, .tick_done, .activity_hint, .thresh_base, .thresh_scale, .layer_key,
        .spike_out, .spike_valid, .axis_state_out, .axis_write_en,
        .max_active_idx, .early_exit_flag
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ==============================
    // Error reporting
    // ==============================
    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        $display("CHECK FAILED: %s got 0x%0h expected 0x%0h", name, got, exp);
        $display("sim failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic stop_with_error(input string what);
        $display("ERROR: %s", what);
        $display("sim failed");
        $fatal(1, "stopping at first error");
    endtask

    // Quiet state between reset and the first tick
    task automatic check_quiet_outputs();
        assert (tick_done == 1'b0) else report_mismatch("tick_done", tick_done, 0);
        assert (spike_valid == 1'b0) else report_mismatch("spike_valid", spike_valid, 0);
        assert (axis_write_en == 1'b0)
            else report_mismatch("axis_write_en", axis_write_en, 0);
        assert (early_exit_flag == 1'b0)
            else report_mismatch("early_exit_flag", early_exit_flag, 0);
        assert (pready == 1'b1) else report_mismatch("pready", pready, 1);
    endtask

    function automatic logic word_nonzero(input int w);
        logic hit;
        hit = 1'b0;
        for (int l = 0; l < LANES; l++)
            if (bank_mdl[parity_mdl][w][l] != '0)
                hit = 1'b1;
        return hit;
    endfunction

    // ==============================
    // Stimulus tasks
    // ==============================
    // Single lane write with setup, access and wait states
    task automatic apb_write(input int word, input int lane, input current_t value);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= 8'(word * 4 + lane);
        pwdata  <= 32'(value);
        @(posedge clk);
        penable <= 1'b1;
        last_stalled = 1'b0;
        @(negedge clk);
        while (!pready) begin
            last_stalled = 1'b1;
            @(negedge clk);
        end
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        bank_mdl[parity_mdl][word][lane] = value;
    endtask

    task automatic run_tick(input bank_addr_t hint);
        logic [LANES-1:0]   exp_spikes;
        logic [LANES*W-1:0] exp_axis;
        logic               exp_exit;
        bank_addr_t         exp_max;
        int                 sums [LANES];
        int                 n_read;
        int                 thr;
        int                 leaked;
        int                 next_mem;
        int                 key;

        // Early exit when nothing is active below the hint
        exp_exit = 1'b1;
        exp_max  = '0;
        for (int w = 0; w < int'(hint); w++)
            if (word_nonzero(w))
                exp_exit = 1'b0;
        n_read = exp_exit ? int'(hint) : DEPTH;
        for (int l = 0; l < LANES; l++)
            sums[l] = 0;
        for (int w = 0; w < n_read; w++) begin
            if (word_nonzero(w))
                exp_max = bank_addr_t'(w);
            for (int l = 0; l < LANES; l++) begin
                sums[l] = sums[l] + int'(bank_mdl[parity_mdl][w][l]);
                if (sums[l] > 65535)
                    sums[l] = 65535;
            end
        end

        // Leaky integrate and fire against the scaled threshold
        thr = (int'(thresh_base) * int'(thresh_scale)) >> `TILE_SCALE_SHIFT;
        for (int l = 0; l < LANES; l++) begin
            leaked   = int'(mem_mdl[l]) - (int'(mem_mdl[l]) >> `TILE_DECAY_SHIFT);
            next_mem = leaked + sums[l];
            key      = int'($signed(layer_key[l*W +: W]));
            exp_spikes[l] = (next_mem >= thr);
            if (exp_spikes[l]) begin
                mem_mdl[l] = '0;
                exp_axis[l*W +: W] = 8'(key * 127);
            end else begin
                mem_mdl[l] = (next_mem > 65535) ? 16'hffff : membrane_t'(next_mem);
                exp_axis[l*W +: W] = '0;
            end
        end

        @(posedge clk);
        activity_hint <= hint;
        tick_start    <= 1'b1;
        // Held until a clear finishes and the sequencer takes it
        @(negedge clk);
        while (!pready)
            @(negedge clk);
        @(posedge clk);
        tick_start <= 1'b0;

        @(negedge clk);
        while (!spike_valid)
            @(negedge clk);
        assert (spike_out == exp_spikes)
            else report_mismatch("spike_out", spike_out, exp_spikes);
        assert (axis_state_out == exp_axis)
            else report_mismatch("axis_state_out", axis_state_out, exp_axis);
        @(negedge clk);
        assert (tick_done) else stop_with_error("tick_done did not follow spike_valid");
        assert (early_exit_flag == exp_exit)
            else report_mismatch("early_exit_flag", early_exit_flag, exp_exit);
        assert (max_active_idx == exp_max)
            else report_mismatch("max_active_idx", max_active_idx, exp_max);

        // Consumed bank is zeroed and writes move to the other one
        for (int w = 0; w < DEPTH; w++)
            for (int l = 0; l < LANES; l++)
                bank_mdl[parity_mdl][w][l] = '0;
        parity_mdl = ~parity_mdl;
    endtask

    // ==============================
    // Protocol assertions
    // ==============================
    a_strobes_paired: assert property (
        @(posedge clk) disable iff (!rst_n) spike_valid == axis_write_en
    ) else report_mismatch("axis_write_en", axis_write_en, spike_valid);

    a_valid_then_done: assert property (
        @(posedge clk) disable iff (!rst_n) spike_valid |=> tick_done
    ) else stop_with_error("tick_done did not follow spike_valid");

    a_done_after_valid: assert property (
        @(posedge clk) disable iff (!rst_n) tick_done |-> $past(spike_valid)
    ) else stop_with_error("tick_done arrived without spike_valid before it");

    // Write-only slave without an error response
    a_apb_status: assert property (
        @(posedge clk) disable iff (!rst_n) !pslverr && prdata == '0
    ) else stop_with_error("APB slave returned read data or an error");

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("ERROR: watchdog expired before the test sequence finished");
        $display("sim failed");
        $fatal(1, "timeout");
    end

    // ==============================
    // Test sequence
    // ==============================
    initial begin
        seed       = 32'hd0ee;
        parity_mdl = 1'b0;
        scales     = '{90, 128, 166};
        for (int b = 0; b < 2; b++)
            for (int w = 0; w < DEPTH; w++)
                for (int l = 0; l < LANES; l++)
                    bank_mdl[b][w][l] = '0;
        for (int l = 0; l < LANES; l++)
            mem_mdl[l] = '0;

        rst_n         <= 1'b0;
        psel          <= 1'b0;
        penable       <= 1'b0;
        pwrite        <= 1'b0;
        paddr         <= '0;
        pwdata        <= '0;
        tick_start    <= 1'b0;
        activity_hint <= 3'd7;
        thresh_base   <= 16'd2000;
        thresh_scale  <= 8'd128;
        layer_key     <= 32'h05fd_8001;

        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(negedge clk);
            check_quiet_outputs();
        end
        @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) begin
            @(negedge clk);
            check_quiet_outputs();
        end

        // Full scan over a randomly loaded bank
        for (int w = 0; w < DEPTH; w++)
            for (int l = 0; l < LANES; l++)
                apb_write(w, l, current_t'($random(seed) & 16'h01ff));
        @(negedge clk);
        check_quiet_outputs();
        run_tick(3'd7);

        // Membranes carry over between ticks
        for (int t = 0; t < 4; t++) begin
            for (int n = 0; n < 6; n++) begin
                apb_write($random(seed) & 7, $random(seed) & 3,
                          current_t'($random(seed) & 16'h03ff));
                if (n == 0)
                    assert (last_stalled)
                        else stop_with_error("APB write after tick_done was not held off by pready");
            end
            run_tick(3'd7);
        end

        // Only words above the hint loaded
        apb_write(5, 0, 16'hffff);
        apb_write(7, 3, 16'hffff);
        run_tick(3'd4);
        assert (early_exit_flag) else report_mismatch("early_exit_flag", early_exit_flag, 1);
        assert (max_active_idx == '0)
            else report_mismatch("max_active_idx", max_active_idx, 0);
        assert (spike_out == '0) else report_mismatch("spike_out", spike_out, 0);

        // Active word below the hint forces a full scan
        apb_write(2, 1, 16'h0040);
        apb_write(6, 2, 16'h0030);
        run_tick(3'd4);
        assert (!early_exit_flag) else report_mismatch("early_exit_flag", early_exit_flag, 0);
        assert (max_active_idx == 3'd6)
            else report_mismatch("max_active_idx", max_active_idx, 6);

        // Both banks drained with nothing rewritten
        run_tick(3'd7);
        run_tick(3'd7);
        assert (early_exit_flag) else report_mismatch("early_exit_flag", early_exit_flag, 1);
        assert (max_active_idx == '0)
            else report_mismatch("max_active_idx", max_active_idx, 0);

        // Same currents under three threshold scales
        @(posedge clk);
        thresh_base <= 16'd1000;
        for (int s = 0; s < 3; s++) begin
            @(posedge clk);
            thresh_scale <= 8'(scales[s]);
            apb_write(0, 0, 16'd650);
            assert (last_stalled)
                else stop_with_error("APB write after tick_done was not held off by pready");
            apb_write(0, 1, 16'd900);
            apb_write(0, 2, 16'd1200);
            apb_write(0, 3, 16'd1500);
            run_tick(3'd7);
        end

        $display("sim passed");
        $finish;
    end

endmodule

// File: tb.f
+incdir+design
design/neuron_pkg.sv
design/ctrl_pkg.sv
design/tile_if.sv
design/apb_load_decode.sv
design/current_banks.sv
design/tick_sequencer.sv
design/lif_execute.sv
design/axis_result.sv
design/kitten_tile_top.sv
test/tb_top.sv

// File: Bender.yml
package:
  name: kitten_tile

export_include_dirs:
  - design

sources:
  - files:
      - design/neuron_pkg.sv
      - design/ctrl_pkg.sv
      - design/tile_if.sv
      - design/apb_load_decode.sv
      - design/current_banks.sv
      - design/tick_sequencer.sv
      - design/lif_execute.sv
      - design/axis_result.sv
      - design/kitten_tile_top.sv
  - target: simulation
    files:
      - test/tb_top.sv
